//--- logic/armControlPkg.sv
`default_nettype none

package armControlPkg;

  // ====================
  // Widths
  // ====================
  localparam int wordWidth = 32;  // Instruction and data
  localparam int flagWidth = 4;   // NZCV

  // ====================
  // Instruction fields
  // ====================
  localparam int condHi   = 31;  // Condition field
  localparam int condLo   = 28;
  localparam int classHi  = 27;  // Class field
  localparam int classLo  = 26;
  localparam int immBit   = 25;  // I bit
  localparam int opHi     = 24;  // Data-processing opcode
  localparam int opLo     = 21;
  localparam int upBit    = 23;  // U bit, add or subtract offset
  localparam int byteBit  = 22;  // B bit, byte access
  localparam int sLoadBit = 20;  // S bit for data processing, L bit for memory
  localparam int rdHi     = 15;  // Destination register
  localparam int rdLo     = 12;

  localparam logic [3:0] pcRegister = 4'd15;  // R15

  // Flag bit positions inside NZCV
  localparam int nIdx = 3;
  localparam int zIdx = 2;
  localparam int cIdx = 1;
  localparam int vIdx = 0;

  // Condition codes, NV acts as never
  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } condCode;

  // Data-processing opcodes, ARM order
  typedef enum logic [3:0] {
    AND, EOR, SUB, RSB, ADD, ADC, SBC, RSC,
    TST, TEQ, CMP, CMN, ORR, MOV, BIC, MVN
  } aluOp;

  // Bits 27:26 of the instruction
  typedef enum logic [1:0] {
    dataProcessing = 2'b00,
    loadStore      = 2'b01,
    branch         = 2'b10,
    undefinedClass = 2'b11
  } instrClass;

  // Test ops only touch the flags
  localparam aluOp noWriteOps [4] = '{TST, TEQ, CMP, CMN};

  function automatic logic isNoWriteOp(input aluOp op);
    logic hit;
    hit = 1'b0;
    foreach (noWriteOps[i]) hit |= (op == noWriteOps[i]);
    return hit;
  endfunction

endpackage

`default_nettype wire

//--- logic/instrDecoder.sv
`default_nettype none

module instrDecoder (
  input  logic [armControlPkg::wordWidth-1:0] instrD,
  output logic [1:0]                          regSrcD,      // Register file read select
  output logic [1:0]                          immSrcD,      // Immediate extend select
  output logic                                aluSrcD,      // Immediate into ALU B
  output logic                                memtoRegD,
  output logic                                regWriteD,
  output logic                                memWriteD,
  output logic                                branchD,
  output logic                                pcSrcD,       // Writes the PC
  output logic                                byteAccessD,  // LDRB or STRB
  output armControlPkg::aluOp                 aluControlD,
  output logic                                flagWriteD    // S bit
);

  armControlPkg::instrClass classD;
  armControlPkg::aluOp      opD;
  logic [3:0]               rdD;

  // Field extraction
  assign classD = armControlPkg::instrClass'(
                    instrD[armControlPkg::classHi:armControlPkg::classLo]);
  assign opD    = armControlPkg::aluOp'(instrD[armControlPkg::opHi:armControlPkg::opLo]);
  assign rdD    = instrD[armControlPkg::rdHi:armControlPkg::rdLo];

  // ====================
  // Main decode
  // ====================
  always_comb begin
    // Bubble unless a class below says otherwise
    regSrcD     = 2'b00;
    immSrcD     = 2'b00;
    aluSrcD     = 1'b0;
    memtoRegD   = 1'b0;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    branchD     = 1'b0;
    byteAccessD = 1'b0;
    aluControlD = armControlPkg::ADD;
    flagWriteD  = 1'b0;
    case (classD)
      armControlPkg::dataProcessing: begin
        aluSrcD     = instrD[armControlPkg::immBit];       // I=1 is rotated imm8
        aluControlD = opD;                                  // Opcode straight through
        flagWriteD  = instrD[armControlPkg::sLoadBit];
        regWriteD   = !armControlPkg::isNoWriteOp(opD);     // TST/TEQ/CMP/CMN
      end
      armControlPkg::loadStore: begin
        immSrcD     = 2'b01;                                // imm12 offset
        aluSrcD     = !instrD[armControlPkg::immBit];       // I=0 means immediate offset here
        aluControlD = instrD[armControlPkg::upBit] ? armControlPkg::ADD : armControlPkg::SUB;
        byteAccessD = instrD[armControlPkg::byteBit];
        if (instrD[armControlPkg::sLoadBit]) begin
          memtoRegD = 1'b1;  // LDR, LDRB
          regWriteD = 1'b1;
        end else begin
          regSrcD   = 2'b10;  // STR reads Rd as data
          memWriteD = 1'b1;
        end
      end
      armControlPkg::branch: begin
        regSrcD = 2'b01;  // Base is the PC
        immSrcD = 2'b10;  // imm24 shifted
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      default: begin
        // Coprocessor space not supported
        regSrcD = 2'b00;
      end
    endcase
  end

  // Branch or any write to R15 redirects fetch
  assign pcSrcD = branchD | (regWriteD & (rdD == armControlPkg::pcRegister));

  // A single instruction never both loads a register and stores
  exclusiveWrites: assert final (!(regWriteD && memWriteD))
    else $error("instrDecoder: regWriteD and memWriteD both high for %h", instrD);

endmodule

`default_nettype wire

//--- logic/condUnit.sv
`default_nettype none

module condUnit (
  input  armControlPkg::condCode                condE,
  input  logic                                  flagWriteE,
  input  logic [armControlPkg::flagWidth-1:0]   flagsE,      // Forwarded NZCV
  input  logic [armControlPkg::flagWidth-1:0]   aluFlagsE,   // Fresh ALU NZCV
  output logic                                  condExE,     // Condition passes
  output logic                                  setFlagsE,
  output logic [armControlPkg::flagWidth-1:0]   flagsNextE
);

  logic n, z, c, v;

  assign n = flagsE[armControlPkg::nIdx];
  assign z = flagsE[armControlPkg::zIdx];
  assign c = flagsE[armControlPkg::cIdx];
  assign v = flagsE[armControlPkg::vIdx];

  // ====================
  // Condition table
  // ====================
  always_comb begin
    unique case (condE)
      armControlPkg::EQ: condExE = z;
      armControlPkg::NE: condExE = !z;
      armControlPkg::CS: condExE = c;
      armControlPkg::CC: condExE = !c;
      armControlPkg::MI: condExE = n;
      armControlPkg::PL: condExE = !n;
      armControlPkg::VS: condExE = v;
      armControlPkg::VC: condExE = !v;
      armControlPkg::HI: condExE = c & !z;          // Unsigned higher
      armControlPkg::LS: condExE = !c | z;
      armControlPkg::GE: condExE = (n == v);        // Signed compares
      armControlPkg::LT: condExE = (n != v);
      armControlPkg::GT: condExE = !z & (n == v);
      armControlPkg::LE: condExE = z | (n != v);
      armControlPkg::AL: condExE = 1'b1;
      default:           condExE = 1'b0;            // NV never runs
    endcase
  end

  assign setFlagsE  = flagWriteE & condExE;               // Failed condition keeps flags
  assign flagsNextE = setFlagsE ? aluFlagsE : flagsE;

endmodule

`default_nettype wire

//--- logic/statusFlags.sv
`default_nettype none

module statusFlags (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                stallW,
  input  logic                                setFlagsM,   // Memory instr sets flags
  input  logic [armControlPkg::flagWidth-1:0] flagsNextM,
  input  logic                                setFlagsW,   // Writeback instr sets flags
  input  logic [armControlPkg::flagWidth-1:0] flagsNextW,
  output logic [armControlPkg::flagWidth-1:0] flagsE,      // Seen by the condition check
  output logic [armControlPkg::flagWidth-1:0] flagsW       // Committed NZCV
);

  // ====================
  // Committed NZCV
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      flagsW <= '0;
    end else if (setFlagsW && !stallW) begin
      flagsW <= flagsNextW;  // Commit at the end of writeback
    end
  end

  // Youngest pending result wins
  always_comb begin
    if (setFlagsM) begin
      flagsE = flagsNextM;
    end else if (setFlagsW) begin
      flagsE = flagsNextW;  // Not committed yet
    end else begin
      flagsE = flagsW;
    end
  end

endmodule

`default_nettype wire

//--- logic/executeStage.sv
`default_nettype none

module executeStage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stallE,          // Hold the D/E register
  input  logic                   flushE,          // Bubble into execute
  input  logic                   aluSrcD,
  input  logic                   memtoRegD,
  input  logic                   regWriteD,
  input  logic                   memWriteD,
  input  logic                   branchD,
  input  logic                   pcSrcD,
  input  logic                   byteAccessD,
  input  armControlPkg::aluOp    aluControlD,
  input  logic                   flagWriteD,
  input  armControlPkg::condCode condD,           // Cond field of instrD
  input  logic [1:0]             aluAddrLowE,     // Address bits 1:0
  input  logic                   condExE,         // From condUnit
  output logic                   aluSrcE,
  output armControlPkg::aluOp    aluControlE,
  output armControlPkg::condCode condE,
  output logic                   flagWriteE,
  output logic                   branchTakenE,
  output logic                   regWriteGatedE,
  output logic                   memWriteGatedE,
  output logic                   memtoRegE,
  output logic                   pcSrcGatedE,
  output logic                   byteAccessE,
  output logic [3:0]             byteMaskE        // Store byte lanes
);

  logic regWriteE, memWriteE, branchE, pcSrcE;

  // ====================
  // D/E register
  // ====================
  always_ff @(posedge clk) begin
    if (reset || flushE) begin
      aluSrcE     <= 1'b0;  // Flush wins over stall
      aluControlE <= armControlPkg::AND;
      condE       <= armControlPkg::EQ;
      flagWriteE  <= 1'b0;
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      memtoRegE   <= 1'b0;
      branchE     <= 1'b0;
      pcSrcE      <= 1'b0;
      byteAccessE <= 1'b0;
    end else if (!stallE) begin
      aluSrcE     <= aluSrcD;
      aluControlE <= aluControlD;
      condE       <= condD;
      flagWriteE  <= flagWriteD;
      regWriteE   <= regWriteD;
      memWriteE   <= memWriteD;
      memtoRegE   <= memtoRegD;
      branchE     <= branchD;
      pcSrcE      <= pcSrcD;
      byteAccessE <= byteAccessD;
    end
  end

  // Conditional execution gates every side effect
  assign branchTakenE   = branchE & condExE;
  assign regWriteGatedE = regWriteE & condExE;
  assign memWriteGatedE = memWriteE & condExE;
  assign pcSrcGatedE    = pcSrcE & condExE;

  // One lane for byte access, little endian
  assign byteMaskE = byteAccessE ? (4'b0001 << aluAddrLowE) : 4'b1111;

  // A flushed slot must leave no trace down the pipe
  flushIsBubble: assert property (@(posedge clk) disable iff (reset)
    flushE |=> !(regWriteGatedE || memWriteGatedE || pcSrcGatedE || branchTakenE))
    else $error("executeStage: write active in execute after flushE");

endmodule

`default_nettype wire

//--- logic/memWbStage.sv
`default_nettype none

module memWbStage (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                stallM,
  input  logic                                stallW,
  input  logic                                flushW,
  input  logic                                memWriteGatedE,
  input  logic                                memtoRegE,
  input  logic                                regWriteGatedE,
  input  logic                                pcSrcGatedE,
  input  logic                                byteAccessE,
  input  logic [3:0]                          byteMaskE,
  input  logic                                setFlagsE,
  input  logic [armControlPkg::flagWidth-1:0] flagsNextE,
  input  logic [1:0]                          aluAddrLowE,
  output logic                                memWriteM,
  output logic                                memtoRegM,
  output logic                                regWriteM,
  output logic                                pcSrcM,       // For pcWrPendingF
  output logic [3:0]                          byteMaskM,
  output logic                                setFlagsM,
  output logic [armControlPkg::flagWidth-1:0] flagsNextM,
  output logic                                memtoRegW,
  output logic                                regWriteW,
  output logic                                pcSrcW,
  output logic                                byteLoadW,    // LDRB result select
  output logic [1:0]                          byteOffsetW,
  output logic                                setFlagsW,
  output logic [armControlPkg::flagWidth-1:0] flagsNextW
);

  logic       byteAccessM;
  logic [1:0] byteOffsetM;

  // ====================
  // E/M register
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      memWriteM   <= 1'b0;  // No flush in memory
      memtoRegM   <= 1'b0;
      regWriteM   <= 1'b0;
      pcSrcM      <= 1'b0;
      byteAccessM <= 1'b0;
      setFlagsM   <= 1'b0;
    end else if (!stallM) begin
      memWriteM   <= memWriteGatedE;
      memtoRegM   <= memtoRegE;
      regWriteM   <= regWriteGatedE;
      pcSrcM      <= pcSrcGatedE;
      byteAccessM <= byteAccessE;
      setFlagsM   <= setFlagsE;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallM) begin
      byteMaskM   <= byteMaskE;   // Payload
      byteOffsetM <= aluAddrLowE;
      flagsNextM  <= flagsNextE;
    end
  end

  // ====================
  // M/W register
  // ====================
  always_ff @(posedge clk) begin
    if (reset || flushW) begin
      memtoRegW <= 1'b0;
      regWriteW <= 1'b0;
      pcSrcW    <= 1'b0;
      byteLoadW <= 1'b0;
      setFlagsW <= 1'b0;
    end else if (!stallW) begin
      memtoRegW <= memtoRegM;
      regWriteW <= regWriteM;
      pcSrcW    <= pcSrcM;
      byteLoadW <= byteAccessM & memtoRegM;  // Byte loads only
      setFlagsW <= setFlagsM;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallW) begin
      byteOffsetW <= byteOffsetM;  // Lane of the loaded byte
      flagsNextW  <= flagsNextM;
    end
  end

  // Stored lanes come from executeStage's mask logic
  storeMaskShape: assert property (@(posedge clk) disable iff (reset)
    memWriteM |-> ($onehot(byteMaskM) || (&byteMaskM)))
    else $error("memWbStage: bad byteMaskM %b on store", byteMaskM);

endmodule

`default_nettype wire

//--- logic/armController.sv
`default_nettype none

module armController (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [armControlPkg::wordWidth-1:0] instrD,
  input  logic [armControlPkg::flagWidth-1:0] aluFlagsE,
  input  logic [1:0]                          aluAddrLowE,
  input  logic                                stallE,
  input  logic                                flushE,
  input  logic                                stallM,
  input  logic                                stallW,
  input  logic                                flushW,
  output logic [1:0]                          regSrcD,
  output logic [1:0]                          immSrcD,
  output logic                                aluSrcE,
  output armControlPkg::aluOp                 aluControlE,
  output logic                                branchTakenE,
  output logic                                memWriteM,
  output logic                                memtoRegM,
  output logic                                regWriteM,
  output logic [3:0]                          byteMaskM,
  output logic                                memtoRegW,
  output logic                                regWriteW,
  output logic                                pcSrcW,
  output logic                                byteLoadW,
  output logic [1:0]                          byteOffsetW,
  output logic [armControlPkg::flagWidth-1:0] flagsW,
  output logic                                pcWrPendingF  // Fetch must wait for the PC
);

  // Decode
  logic aluSrcD, memtoRegD, regWriteD, memWriteD, branchD, pcSrcD, byteAccessD, flagWriteD;
  armControlPkg::aluOp aluControlD;
  // Execute
  armControlPkg::condCode condE;
  logic flagWriteE, condExE, setFlagsE, memtoRegE, byteAccessE;
  logic regWriteGatedE, memWriteGatedE, pcSrcGatedE;
  logic [3:0] byteMaskE;
  logic [armControlPkg::flagWidth-1:0] flagsE, flagsNextE;
  // Memory and writeback
  logic setFlagsM, setFlagsW, pcSrcM;
  logic [armControlPkg::flagWidth-1:0] flagsNextM, flagsNextW;

  instrDecoder decoder0 (
    .instrD, .regSrcD, .immSrcD, .aluSrcD, .memtoRegD, .regWriteD, .memWriteD,
    .branchD, .pcSrcD, .byteAccessD, .aluControlD, .flagWriteD
  );

  executeStage execute0 (
    .clk, .reset, .stallE, .flushE, .aluSrcD, .memtoRegD, .regWriteD, .memWriteD,
    .branchD, .pcSrcD, .byteAccessD, .aluControlD, .flagWriteD,
    .condD(armControlPkg::condCode'(instrD[armControlPkg::condHi:armControlPkg::condLo])),
    .aluAddrLowE, .condExE, .aluSrcE, .aluControlE, .condE, .flagWriteE, .branchTakenE,
    .regWriteGatedE, .memWriteGatedE, .memtoRegE, .pcSrcGatedE, .byteAccessE, .byteMaskE
  );

  condUnit cond0 (
    .condE, .flagWriteE, .flagsE, .aluFlagsE, .condExE, .setFlagsE, .flagsNextE
  );

  statusFlags flags0 (
    .clk, .reset, .stallW, .setFlagsM, .flagsNextM, .setFlagsW, .flagsNextW, .flagsE, .flagsW
  );

  memWbStage memWb0 (
    .clk, .reset, .stallM, .stallW, .flushW, .memWriteGatedE, .memtoRegE, .regWriteGatedE,
    .pcSrcGatedE, .byteAccessE, .byteMaskE, .setFlagsE, .flagsNextE, .aluAddrLowE,
    .memWriteM, .memtoRegM, .regWriteM, .pcSrcM, .byteMaskM, .setFlagsM, .flagsNextM,
    .memtoRegW, .regWriteW, .pcSrcW, .byteLoadW, .byteOffsetW, .setFlagsW, .flagsNextW
  );

  // PC write anywhere before writeback blocks fetch
  assign pcWrPendingF = pcSrcD | pcSrcGatedE | pcSrcM;

endmodule

`default_nettype wire

//--- verification/armControllerTb.sv
`default_nettype none

module armControllerTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clkPeriod = 100;
  localparam int numInstr  = 400;      // Issued instructions
  localparam logic [3:0] condAl = 4'hE;

  typedef struct packed {
    logic       valid;                 // Defined class
    logic [3:0] op;
    logic [3:0] cond;
    logic       flagWrite;
    logic       regWrite;
    logic       memWrite;
    logic       memtoReg;
    logic       branch;
    logic       pcSrc;
    logic       byteAcc;
    logic [1:0] regSrc;                // Register read select
    logic [1:0] immSrc;                // Immediate extend select
    logic       aluSrc;
  } decodeT;

  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic       byteAcc;               // Byte load once in writeback
    logic       setFlags;
    logic [3:0] mask;
    logic [1:0] off;
    logic [3:0] flagsNext;
  } laterT;

  logic        clk, reset;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic [1:0]  aluAddrLowE;
  logic        stallE, flushE, stallM, stallW, flushW;
  logic [1:0]  regSrcD, immSrcD;
  logic        aluSrcE, branchTakenE, memWriteM, memtoRegM, regWriteM;
  armControlPkg::aluOp aluControlE;
  logic [3:0]  byteMaskM;
  logic        memtoRegW, regWriteW, pcSrcW, byteLoadW;
  logic [1:0]  byteOffsetW;
  logic [3:0]  flagsW;
  logic        pcWrPendingF;

  logic [31:0] rngState;
  int          issued;
  logic        failSeen;

  // Reference model state
  decodeT     decD, sE;
  laterT      sM, sW;
  logic [3:0] commitFlags, fwdFlags, flagsNextE, maskE;
  logic       passE, setFlagsE, expPcPending;

  armController dut0 (.*);

  always #(clkPeriod / 2) clk = ~clk;

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic condPass(input logic [3:0] cond, input logic [3:0] f);
    logic n, z, c, v;
    n = f[armControlPkg::nIdx];
    z = f[armControlPkg::zIdx];
    c = f[armControlPkg::cIdx];
    v = f[armControlPkg::vIdx];
    case (cond)
      4'd0:    return z;               // EQ
      4'd1:    return !z;
      4'd2:    return c;
      4'd3:    return !c;
      4'd4:    return n;
      4'd5:    return !n;
      4'd6:    return v;
      4'd7:    return !v;
      4'd8:    return c && !z;         // HI
      4'd9:    return !c || z;
      4'd10:   return n == v;          // GE
      4'd11:   return n != v;
      4'd12:   return !z && (n == v);  // GT
      4'd13:   return z || (n != v);
      4'd14:   return 1'b1;            // AL
      default: return 1'b0;            // NV never
    endcase
  endfunction

  // Store lanes, little endian
  function automatic logic [3:0] laneMask(input logic byteAcc, input logic [1:0] off);
    if (!byteAcc) return 4'b1111;      // Word access
    case (off)
      2'd0:    return 4'b0001;
      2'd1:    return 4'b0010;
      2'd2:    return 4'b0100;
      default: return 4'b1000;
    endcase
  endfunction

  function automatic decodeT refDecode(input logic [31:0] instr);
    decodeT d;
    d = '0;
    d.cond = instr[31:28];
    case (instr[27:26])
      2'b00: begin                     // Data processing
        d.valid     = 1'b1;
        d.op        = instr[24:21];
        d.flagWrite = instr[20];
        d.aluSrc    = instr[25];
        d.regWrite  = !(instr[24:21] inside {armControlPkg::TST, armControlPkg::TEQ,
                                             armControlPkg::CMP, armControlPkg::CMN});
      end
      2'b01: begin                     // Load or store
        d.valid    = 1'b1;
        d.op       = instr[23] ? armControlPkg::ADD : armControlPkg::SUB;
        d.byteAcc  = instr[22];
        d.memtoReg = instr[20];
        d.regWrite = instr[20];
        d.memWrite = !instr[20];
        d.immSrc   = 2'b01;
        d.aluSrc   = !instr[25];       // Immediate offset when I is clear
        d.regSrc   = instr[20] ? 2'b00 : 2'b10;
      end
      2'b10: begin
        d.valid  = 1'b1;
        d.op     = armControlPkg::ADD;
        d.branch = 1'b1;
        d.regSrc = 2'b01;              // PC base
        d.immSrc = 2'b10;
        d.aluSrc = 1'b1;
      end
      default: d.valid = 1'b0;         // Bubble
    endcase
    d.pcSrc = d.branch | (d.regWrite & (instr[15:12] == 4'd15));
    return d;
  endfunction

  // Class mix weighted toward data processing, half the conditions AL
  function automatic logic [31:0] makeInstr(input logic [31:0] r0, input logic [31:0] r1);
    logic [31:0] instr;
    instr = r1;
    instr[27:26] = (r0[3:0] < 8) ? 2'b00 : (r0[3:0] < 13) ? 2'b01 : (r0[3:0] < 15) ? 2'b10 : 2'b11;
    instr[31:28] = r0[4] ? condAl : r0[8:5];
    return instr;
  endfunction

  task automatic failRun(input string msg);
    failSeen = 1'b1;
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    failRun($sformatf("CHECK FAILED at %0t: %s expected %0h actual %0h",
                      $time, name, expVal, actVal));
  endtask

  // ====================
  // Reference model
  // ====================
  always_comb begin
    decD = refDecode(instrD);
    if (sM.setFlags) fwdFlags = sM.flagsNext;       // Youngest pending first
    else if (sW.setFlags) fwdFlags = sW.flagsNext;
    else fwdFlags = commitFlags;
    passE        = condPass(sE.cond, fwdFlags);
    setFlagsE    = sE.flagWrite & passE;
    flagsNextE   = setFlagsE ? aluFlagsE : fwdFlags;
    maskE        = laneMask(sE.byteAcc, aluAddrLowE);
    expPcPending = decD.pcSrc | (sE.pcSrc & passE) | sM.pcSrc;
  end

  always @(posedge clk) begin
    if (reset) begin
      sE          <= '0;
      sM          <= '0;
      sW          <= '0;
      commitFlags <= '0;
    end else begin
      if (flushE) sE <= '0;
      else if (!stallE) sE <= decD;
      if (!stallM) begin
        sM <= '{memWrite: sE.memWrite & passE, memtoReg: sE.memtoReg,
                regWrite: sE.regWrite & passE, pcSrc: sE.pcSrc & passE,
                byteAcc: sE.byteAcc, setFlags: setFlagsE, mask: maskE,
                off: aluAddrLowE, flagsNext: flagsNextE};
      end
      if (!stallW) begin
        sW.off       <= sM.off;        // Payload ignores flushW
        sW.flagsNext <= sM.flagsNext;
      end
      if (flushW) begin
        sW.memtoReg <= 1'b0;
        sW.regWrite <= 1'b0;
        sW.pcSrc    <= 1'b0;
        sW.byteAcc  <= 1'b0;
        sW.setFlags <= 1'b0;
      end else if (!stallW) begin
        sW.memtoReg <= sM.memtoReg;
        sW.regWrite <= sM.regWrite;
        sW.pcSrc    <= sM.pcSrc;
        sW.byteAcc  <= sM.byteAcc & sM.memtoReg;
        sW.setFlags <= sM.setFlags;
      end
      if (sW.setFlags && !stallW) commitFlags <= sW.flagsNext;
    end
  end

  // ====================
  // Output checks
  // ====================
  regSrcOk: assert property (@(posedge clk) disable iff (reset) regSrcD == decD.regSrc)
    else reportMismatch("regSrcD", $sampled(decD.regSrc), $sampled(regSrcD));
  immSrcOk: assert property (@(posedge clk) disable iff (reset) immSrcD == decD.immSrc)
    else reportMismatch("immSrcD", $sampled(decD.immSrc), $sampled(immSrcD));
  aluSrcOk: assert property (@(posedge clk) disable iff (reset) aluSrcE == sE.aluSrc)
    else reportMismatch("aluSrcE", $sampled(sE.aluSrc), $sampled(aluSrcE));
  aluControlOk: assert property (@(posedge clk) disable iff (reset)
    sE.valid |-> aluControlE == sE.op)
    else reportMismatch("aluControlE", $sampled(sE.op), $sampled(aluControlE));
  branchOk: assert property (@(posedge clk) disable iff (reset)
    branchTakenE == (sE.branch & passE))
    else reportMismatch("branchTakenE", $sampled(sE.branch & passE), $sampled(branchTakenE));
  memWriteOk: assert property (@(posedge clk) disable iff (reset) memWriteM == sM.memWrite)
    else reportMismatch("memWriteM", $sampled(sM.memWrite), $sampled(memWriteM));
  memtoRegMOk: assert property (@(posedge clk) disable iff (reset) memtoRegM == sM.memtoReg)
    else reportMismatch("memtoRegM", $sampled(sM.memtoReg), $sampled(memtoRegM));
  regWriteMOk: assert property (@(posedge clk) disable iff (reset) regWriteM == sM.regWrite)
    else reportMismatch("regWriteM", $sampled(sM.regWrite), $sampled(regWriteM));
  byteMaskOk: assert property (@(posedge clk) disable iff (reset)
    sM.memWrite |-> byteMaskM == sM.mask)
    else reportMismatch("byteMaskM", $sampled(sM.mask), $sampled(byteMaskM));
  memtoRegWOk: assert property (@(posedge clk) disable iff (reset) memtoRegW == sW.memtoReg)
    else reportMismatch("memtoRegW", $sampled(sW.memtoReg), $sampled(memtoRegW));
  regWriteWOk: assert property (@(posedge clk) disable iff (reset) regWriteW == sW.regWrite)
    else reportMismatch("regWriteW", $sampled(sW.regWrite), $sampled(regWriteW));
  pcSrcWOk: assert property (@(posedge clk) disable iff (reset) pcSrcW == sW.pcSrc)
    else reportMismatch("pcSrcW", $sampled(sW.pcSrc), $sampled(pcSrcW));
  byteLoadOk: assert property (@(posedge clk) disable iff (reset) byteLoadW == sW.byteAcc)
    else reportMismatch("byteLoadW", $sampled(sW.byteAcc), $sampled(byteLoadW));
  byteOffsetOk: assert property (@(posedge clk) disable iff (reset)
    sW.memtoReg |-> byteOffsetW == sW.off)  // Loaded lane
    else reportMismatch("byteOffsetW", $sampled(sW.off), $sampled(byteOffsetW));
  flagsOk: assert property (@(posedge clk) disable iff (reset) flagsW == commitFlags)
    else reportMismatch("flagsW", $sampled(commitFlags), $sampled(flagsW));
  pcPendingOk: assert property (@(posedge clk) disable iff (reset)
    pcWrPendingF == expPcPending)
    else reportMismatch("pcWrPendingF", $sampled(expPcPending), $sampled(pcWrPendingF));

  // Unconditional register write lands three edges after issue with no hold
  alWriteLatency: assert property (@(posedge clk) disable iff (reset)
    (decD.regWrite && decD.cond == condAl && !stallE && !flushE) ##1 !stallM
      ##1 (!stallW && !flushW) |=> regWriteW)
    else failRun("AL register write did not reach writeback three cycles after issue");

  // ====================
  // Stimulus
  // ====================
  initial begin
    logic [31:0] r0, r1;
    int          stallLvl;
    clk         = 1'b0;
    reset       = 1'b1;
    instrD      = '0;
    aluFlagsE   = '0;
    aluAddrLowE = '0;
    stallE      = 1'b0;
    flushE      = 1'b0;
    stallM      = 1'b0;
    stallW      = 1'b0;
    flushW      = 1'b0;
    failSeen    = 1'b0;
    issued      = 0;
    rngState    = 32'd30825;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    while (issued < numInstr) begin
      @(posedge clk);
      rngState = xorshift32(rngState);
      r0 = rngState;
      rngState = xorshift32(rngState);
      r1 = rngState;
      stallLvl = (r0[12:9] == 4'd0) ? 1 + (r0[14:13] % 3) : 0;  // Hold up to E, M or W
      stallE      <= (stallLvl >= 1);
      stallM      <= (stallLvl >= 2);
      stallW      <= (stallLvl >= 3);
      flushE      <= (stallLvl == 0) && (r0[18:15] == 4'd0);
      flushW      <= (stallLvl == 0) && (r0[23:19] == 5'd0);
      aluFlagsE   <= r0[27:24];
      aluAddrLowE <= r0[29:28];
      if (stallLvl == 0) begin
        instrD <= makeInstr(r0, r1);  // Decode holds its word while stalled
        issued++;
      end
    end
    @(posedge clk);
    stallE <= 1'b0;
    stallM <= 1'b0;
    stallW <= 1'b0;
    flushE <= 1'b0;
    flushW <= 1'b0;
    repeat (8) @(posedge clk);  // Drain the pipe
    if (!failSeen) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "Errors were reported");
    end
  end

  // Watchdog sized from the instruction count
  initial begin
    #((numInstr * 10 + 50) * clkPeriod);
    $display("Watchdog timeout: the run did not finish in time");
    $display("TESTS FAILED");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire

//--- armController.f
logic/armControlPkg.sv
logic/instrDecoder.sv
logic/condUnit.sv
logic/statusFlags.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/armController.sv
verification/armControllerTb.sv
